/* Makefile */
VERILATOR ?= verilator
TOP       := tb_fetch_unit
FILELIST  := project.f
FLAGS     := --timing --assert
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJDIR)/V$(TOP): $(shell grep -v '^+' $(FILELIST)) fetch_cfg.svh
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

sim: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q '>>> PASS' $(LOG) || { echo "no pass reported"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)

/* fetch_align_buffer.sv */
// ================================================
// halfword realignment of the fetched word stream
// emits whole 16/32-bit instructions with their pc
// redirect restarts fetch at any halfword pc
// ================================================
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_align_buffer (
    input  logic                     clk,
    input  logic                     n_rst,
    input  logic                     redirect_valid,
    input  logic [`FETCH_ADDR_W-1:0] redirect_pc,
    output logic                     word_req,
    output logic [`FETCH_ADDR_W-1:0] word_addr,
    output logic                     flush,
    input  logic                     word_valid,
    input  fetch_pkg::word_beat_t    word,
    output fetch_pkg::raw_inst_t     raw,
    output logic                     raw_valid,
    input  logic                     raw_ready
);
    localparam int            AW       = `FETCH_ADDR_W;
    localparam logic [AW-1:0] RESET_PC = `FETCH_RESET_PC;

    fetch_pkg::align_state_e state, state_n;
    logic [AW-1:0] pc, pc_n;   // pc of the instruction at the head
    logic [AW-1:0] fetch_addr; // next word to read, runs ahead of pc
    logic [31:0]   wbuf;       // current word
    logic [15:0]   hold;       // lower half of a straddling 32-bit instr
    logic          werr, herr;
    logic          split_full; // SPLIT has its second word
    logic          waiting, take_word, take_raw;
    logic          lo_is_c, go_high;
    logic [15:0]   hi_src;
    logic          hi_err;

    assign lo_is_c = (wbuf[1:0] != 2'b11);

    // needs a word while empty or while a straddle is incomplete
    assign waiting   = (state == fetch_pkg::EMPTY) | ((state == fetch_pkg::SPLIT) & !split_full);
    assign flush     = redirect_valid;
    assign word_req  = waiting & !word_valid & !redirect_valid;
    assign word_addr = fetch_addr;
    assign take_word = word_valid & waiting & !redirect_valid;  // redirect wins
    assign take_raw  = raw_valid & raw_ready & !redirect_valid;

    // upper half that becomes the head when moving up
    assign hi_src = take_word ? word.data[31:16] : wbuf[31:16];
    assign hi_err = take_word ? word.err : werr;

    always_comb begin
        raw_valid         = 1'b0;
        raw.pc            = pc;
        raw.bits          = wbuf;
        raw.is_compressed = 1'b0;
        raw.err           = werr;
        case (state)
            fetch_pkg::HAVE_LOW: begin
                raw_valid         = 1'b1;
                raw.is_compressed = lo_is_c;
                if (lo_is_c)
                    raw.bits = {16'h0000, wbuf[15:0]};
            end
            fetch_pkg::HAVE_HIGH: begin  // only ever holds a compressed upper half
                raw_valid         = 1'b1;
                raw.is_compressed = 1'b1;
                raw.bits          = {16'h0000, wbuf[31:16]};
            end
            fetch_pkg::SPLIT: begin
                raw_valid = split_full;
                raw.bits  = {wbuf[15:0], hold};  // joined across the word boundary
                raw.err   = werr | herr;
            end
            default: ;
        endcase
    end

    // next state, word arrival and consumption never coincide
    always_comb begin
        state_n = state;
        pc_n    = pc;
        go_high = 1'b0;
        if (take_word) begin
            if (state == fetch_pkg::EMPTY) begin
                if (pc[1])
                    go_high = 1'b1;  // misaligned redirect, skip lower half
                else
                    state_n = fetch_pkg::HAVE_LOW;
            end
        end else if (take_raw) begin
            case (state)
                fetch_pkg::HAVE_LOW: begin
                    if (lo_is_c) begin
                        pc_n    = pc + AW'(2);
                        go_high = 1'b1;
                    end else begin
                        pc_n    = pc + AW'(4);
                        state_n = fetch_pkg::EMPTY;
                    end
                end
                fetch_pkg::HAVE_HIGH: begin
                    pc_n    = pc + AW'(2);
                    state_n = fetch_pkg::EMPTY;
                end
                fetch_pkg::SPLIT: begin
                    pc_n    = pc + AW'(4);
                    go_high = 1'b1;  // upper half of the new word is next
                end
                default: ;
            endcase
        end
        if (go_high)
            state_n = (hi_src[1:0] != 2'b11) ? fetch_pkg::HAVE_HIGH : fetch_pkg::SPLIT;
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state      <= fetch_pkg::EMPTY;
            pc         <= RESET_PC;
            fetch_addr <= {RESET_PC[AW-1:2], 2'b00};
            split_full <= 1'b0;
        end else if (redirect_valid) begin
            state      <= fetch_pkg::EMPTY;
            pc         <= {redirect_pc[AW-1:1], 1'b0};
            fetch_addr <= {redirect_pc[AW-1:2], 2'b00};
            split_full <= 1'b0;
        end else begin
            state <= state_n;
            pc    <= pc_n;
            if (take_word)
                fetch_addr <= word.addr + AW'(4);
            if (take_word && state == fetch_pkg::SPLIT)
                split_full <= 1'b1;
            else if (go_high)
                split_full <= 1'b0;  // fresh straddle waits again
        end
    end

    always_ff @(posedge clk) begin
        if (take_word) begin
            wbuf <= word.data;
            werr <= word.err;
        end
        if (go_high) begin
            hold <= hi_src;
            herr <= hi_err;
        end
    end

endmodule

/* fetch_cfg.svh */
// ================================================
// build-time constants for the fetch front end
// include wherever a width or reset pc is needed
// ================================================
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// pc and axi address width
`define FETCH_ADDR_W 32

// first pc fetched after reset
`define FETCH_RESET_PC 32'h0000_0000

// program memory size of the testbench model, in words
`define FETCH_PROG_WORDS 16

`endif

/* fetch_pkg.sv */
// ================================================
// shared types for the fetch front end
// axi read payloads, internal beats and fsm states
// referenced as fetch_pkg::name from rtl and tb
// ================================================
`include "fetch_cfg.svh"

package fetch_pkg;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axil_resp_e;

    typedef struct packed {
        logic [`FETCH_ADDR_W-1:0] addr;
        logic [2:0]               prot;  // bit 2 set for instruction access
    } axil_ar_t;

    typedef struct packed {
        logic [31:0] data;
        axil_resp_e  resp;
    } axil_r_t;

    // one word as handed from reader to realignment buffer
    typedef struct packed {
        logic [31:0]              data;
        logic [`FETCH_ADDR_W-1:0] addr;  // word aligned
        logic                     err;   // resp was not OKAY
    } word_beat_t;

    typedef struct packed {
        logic [`FETCH_ADDR_W-1:0] pc;
        logic [31:0]              bits;           // compressed ones zero-extended
        logic                     is_compressed;
        logic                     err;            // any source word had a bus error
    } raw_inst_t;

    typedef struct packed {
        logic [`FETCH_ADDR_W-1:0] pc;
        logic [31:0]              instr;          // always the 32-bit form
        logic                     is_compressed;
        logic                     illegal;        // unsupported rvc, passed through
        logic                     bus_err;
    } fetch_out_t;

    typedef enum logic [2:0] {C_NOP, C_ADDI, C_LI, C_MV, C_ADD, C_OTHER} rvc_op_e;

    typedef enum logic [1:0] {EMPTY, HAVE_LOW, HAVE_HIGH, SPLIT} align_state_e;

    typedef enum logic [1:0] {IDLE, ADDR, DATA} reader_state_e;

endpackage

/* fetch_unit_checker.sv */
// ==================================================
// handshake assertions for the fetch front end
// bound into the top level, reports via $error only
// ==================================================
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_unit_checker (
    input logic                  clk,
    input logic                  n_rst,
    input logic                  redirect_valid,
    input fetch_pkg::axil_ar_t   ar,
    input logic                  arvalid,
    input logic                  arready,
    input logic                  rvalid,
    input logic                  rready,
    input fetch_pkg::fetch_out_t out,
    input logic                  out_valid,
    input logic                  out_ready
);
    logic outstanding;  // an AR was accepted, R not yet seen

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst)
            outstanding <= 1'b0;
        else if (arvalid && arready)
            outstanding <= 1'b1;
        else if (rvalid && rready)
            outstanding <= 1'b0;
    end

    ar_hold: assert property (@(posedge clk) disable iff (!n_rst)
        arvalid && !arready |=> arvalid && $stable(ar))
        else $error("ar changed or dropped while stalled");

    // a redirect flushes the output register, so it may drop a held one
    out_hold: assert property (@(posedge clk) disable iff (!n_rst)
        out_valid && !out_ready && !redirect_valid |=> out_valid && $stable(out))
        else $error("out changed or dropped while stalled");

    one_read: assert property (@(posedge clk) disable iff (!n_rst)
        arvalid |-> !outstanding)
        else $error("second AR while a read is outstanding");

    ar_range: assert property (@(posedge clk) disable iff (!n_rst)
        arvalid |-> ar.addr < 4 * `FETCH_PROG_WORDS)
        else $error("AR address beyond program");

endmodule

bind fetch_unit_top fetch_unit_checker u_checker (
    .clk(clk), .n_rst(n_rst), .redirect_valid(redirect_valid), .ar(ar),
    .arvalid(arvalid), .arready(arready), .rvalid(rvalid), .rready(rready),
    .out(out), .out_valid(out_valid), .out_ready(out_ready)
);

/* fetch_unit_top.sv */
// ================================================
// fetch front end top, axi4-lite read side in
// expanded instructions with pc out to decode
// ================================================
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_unit_top (
    input  logic                     clk,
    input  logic                     n_rst,
    input  logic                     redirect_valid,
    input  logic [`FETCH_ADDR_W-1:0] redirect_pc,
    output fetch_pkg::axil_ar_t      ar,
    output logic                     arvalid,
    input  logic                     arready,
    input  fetch_pkg::axil_r_t       r,
    input  logic                     rvalid,
    output logic                     rready,
    output fetch_pkg::fetch_out_t    out,
    output logic                     out_valid,
    input  logic                     out_ready
);
    logic                     word_req, word_valid, flush;
    logic [`FETCH_ADDR_W-1:0] word_addr;
    fetch_pkg::word_beat_t    word;
    fetch_pkg::raw_inst_t     raw;
    logic                     raw_valid, raw_ready;

    imem_axil_reader u_reader (
        .clk, .n_rst, .word_req, .word_addr, .flush, .word_valid, .word,
        .ar, .arvalid, .arready, .r, .rvalid, .rready
    );

    fetch_align_buffer u_align (
        .clk, .n_rst, .redirect_valid, .redirect_pc,
        .word_req, .word_addr, .flush,  // flush fans out to reader and expander
        .word_valid, .word, .raw, .raw_valid, .raw_ready
    );

    rvc_expander u_expand (
        .clk, .n_rst, .raw, .raw_valid, .raw_ready, .flush,
        .out, .out_valid, .out_ready
    );

endmodule

/* imem_axil_reader.sv */
// ================================================
// axi4-lite read master for instruction memory
// one aligned word per request, one read in flight
// flushed reads finish on the bus, data is dropped
// ================================================
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module imem_axil_reader (
    input  logic                     clk,
    input  logic                     n_rst,
    input  logic                     word_req,
    input  logic [`FETCH_ADDR_W-1:0] word_addr,
    input  logic                     flush,
    output logic                     word_valid,
    output fetch_pkg::word_beat_t    word,
    output fetch_pkg::axil_ar_t      ar,
    output logic                     arvalid,
    input  logic                     arready,
    input  fetch_pkg::axil_r_t       r,
    input  logic                     rvalid,
    output logic                     rready
);
    localparam int AW = `FETCH_ADDR_W;

    fetch_pkg::reader_state_e state;
    logic [AW-1:0] ar_addr;  // held stable while arvalid is up
    logic          drop;     // read in flight belongs to a stale stream
    logic          start, ar_hs, r_hs;

    assign start   = (state == fetch_pkg::IDLE) & word_req;
    assign arvalid = (state == fetch_pkg::ADDR);
    assign rready  = (state == fetch_pkg::DATA);
    assign ar_hs   = arvalid & arready;
    assign r_hs    = rready & rvalid;

    assign ar = '{addr: ar_addr, prot: 3'b100};  // unprivileged, secure, instruction

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state      <= fetch_pkg::IDLE;
            drop       <= 1'b0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= 1'b0;  // single cycle pulse
            case (state)
                fetch_pkg::IDLE: if (start) state <= fetch_pkg::ADDR;
                fetch_pkg::ADDR: if (ar_hs) state <= fetch_pkg::DATA;
                fetch_pkg::DATA: begin
                    if (r_hs) begin
                        state      <= fetch_pkg::IDLE;
                        word_valid <= !(drop | flush);  // a flush this cycle also kills it
                    end
                end
                default: state <= fetch_pkg::IDLE;
            endcase
            // remember a flush that lands while the bus is busy
            if (r_hs)
                drop <= 1'b0;
            else if (flush && state != fetch_pkg::IDLE)
                drop <= 1'b1;
        end
    end

    // address and returned data
    always_ff @(posedge clk) begin
        if (start)
            ar_addr <= {word_addr[AW-1:2], 2'b00};  // force word alignment
        if (r_hs) begin
            word.data <= r.data;
            word.addr <= ar_addr;
            word.err  <= (r.resp != fetch_pkg::OKAY);
        end
    end

endmodule

/* project.f */
+incdir+.
fetch_pkg.sv
imem_axil_reader.sv
fetch_align_buffer.sv
rvc_expander.sv
fetch_unit_top.sv
fetch_unit_checker.sv
tb_fetch_unit.sv

/* rvc_expander.sv */
// ================================================
// expands supported rvc instructions to 32 bits
// c.nop c.addi c.li c.mv c.add, others flagged
// one register stage toward the decode stage
// ================================================
`timescale 1ns/1ps

module rvc_expander (
    input  logic                 clk,
    input  logic                 n_rst,
    input  fetch_pkg::raw_inst_t raw,
    input  logic                 raw_valid,
    output logic                 raw_ready,
    input  logic                 flush,
    output fetch_pkg::fetch_out_t out,
    output logic                 out_valid,
    input  logic                 out_ready
);
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    fetch_pkg::rvc_op_e op;
    logic [15:0] c;
    logic [4:0]  rd, rs2;
    logic [11:0] imm;        // sign-extended 6-bit immediate
    logic [31:0] exp_instr;
    logic        illegal;
    logic        load;

    assign c   = raw.bits[15:0];
    assign rd  = c[11:7];
    assign rs2 = c[6:2];
    assign imm = {{6{c[12]}}, c[12], c[6:2]};

    // classify by funct3 and quadrant
    always_comb begin
        case ({c[15:13], c[1:0]})
            5'b000_01: op = (rd == 5'd0) ? fetch_pkg::C_NOP : fetch_pkg::C_ADDI;
            5'b010_01: op = fetch_pkg::C_LI;
            5'b100_10: begin
                if (rs2 == 5'd0)
                    op = fetch_pkg::C_OTHER;  // jr, jalr, ebreak
                else
                    op = c[12] ? fetch_pkg::C_ADD : fetch_pkg::C_MV;
            end
            default:   op = fetch_pkg::C_OTHER;
        endcase
    end

    always_comb begin
        illegal = 1'b0;
        if (!raw.is_compressed) begin
            exp_instr = raw.bits;  // 32-bit passes untouched
        end else begin
            case (op)
                fetch_pkg::C_NOP:  exp_instr = {12'h000, 5'd0, 3'b000, 5'd0, OPC_OP_IMM};
                fetch_pkg::C_ADDI: exp_instr = {imm, rd, 3'b000, rd, OPC_OP_IMM};
                fetch_pkg::C_LI:   exp_instr = {imm, 5'd0, 3'b000, rd, OPC_OP_IMM}; // addi rd,x0
                fetch_pkg::C_MV:   exp_instr = {7'b0, rs2, 5'd0, 3'b000, rd, OPC_OP}; // add rd,x0
                fetch_pkg::C_ADD:  exp_instr = {7'b0, rs2, rd, 3'b000, rd, OPC_OP};
                default: begin
                    exp_instr = {16'h0000, c};
                    illegal   = 1'b1;
                end
            endcase
        end
    end

    // accept when empty or the held one leaves this cycle
    assign raw_ready = !out_valid | out_ready;
    assign load      = raw_valid & raw_ready & !flush;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst)
            out_valid <= 1'b0;
        else if (flush)
            out_valid <= 1'b0;  // stale stream
        else if (load)
            out_valid <= 1'b1;
        else if (out_ready)
            out_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out.pc            <= raw.pc;
            out.instr         <= exp_instr;
            out.is_compressed <= raw.is_compressed;
            out.illegal       <= illegal;
            out.bus_err       <= raw.err;
        end
    end

endmodule

/* tb_fetch_unit.sv */
// ==================================================
// testbench for the fetch front end
// axi4-lite memory model with random stalls, program
// table and expected-output table checked in a loop
// ==================================================
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module tb_fetch_unit;
    localparam int NEXP  = 20;             // expected outputs
    localparam int NRED  = 3;              // redirect points
    localparam int LIMIT = 20 * NEXP;      // cycle budget
    localparam int NHW   = 2 * `FETCH_PROG_WORDS;
    localparam logic [`FETCH_ADDR_W-1:0] RESET_PC = `FETCH_RESET_PC;

    logic                     clk = 1'b0;
    logic                     n_rst;
    logic                     redirect_valid;
    logic [`FETCH_ADDR_W-1:0] redirect_pc;
    fetch_pkg::axil_ar_t      ar;
    logic                     arvalid, arready;
    fetch_pkg::axil_r_t       r;
    logic                     rvalid, rready;
    fetch_pkg::fetch_out_t    out;
    logic                     out_valid, out_ready;

    logic [15:0]              prog [0:NHW-1];     // program as halfwords
    fetch_pkg::fetch_out_t    exp_tab [0:NEXP-1];
    int                       redir_after [0:NRED-1];
    logic [31:0]              redir_pc [0:NRED-1];
    logic [31:0]              lfsr = 32'he8a0;
    int                       errors, ar_checks, n_exp;
    logic [31:0]              rd_addr;
    int                       ar_wait, r_wait;
    logic                     r_pending;
    logic [`FETCH_ADDR_W-1:0] ar_exp;      // word the next AR must carry
    logic [`FETCH_ADDR_W-1:0] redir_word;  // restart word once a stalled AR is gone
    logic                     redir_pend;

    fetch_unit_top UUT (.*);

    always #20 clk = ~clk;

    // galois lfsr, one step per bit taken
    function automatic int draw_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v    = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    // a 32-bit instruction sits in two halfwords, low half first
    task automatic store_wide(input int hw, input logic [31:0] inst);
        prog[hw]     = inst[15:0];
        prog[hw + 1] = inst[31:16];
    endtask

    task automatic add_exp(input logic [31:0] pc, input logic [31:0] instr,
                           input logic is_c, input logic ill);
        exp_tab[n_exp] = '{pc: pc, instr: instr, is_compressed: is_c, illegal: ill,
                           bus_err: 1'b0};
        n_exp++;
    endtask

    task automatic check_out(input fetch_pkg::fetch_out_t got,
                             input fetch_pkg::fetch_out_t exp, input int idx);
        int bad;
        bad = 0;
        if (got.pc !== exp.pc) begin
            $display("MISMATCH out.pc exp %h got %h", exp.pc, got.pc);
            bad++;
        end
        if (got.instr !== exp.instr) begin
            $display("MISMATCH out.instr exp %h got %h", exp.instr, got.instr);
            bad++;
        end
        if (got.is_compressed !== exp.is_compressed) begin
            $display("MISMATCH out.is_compressed exp %h got %h",
                     exp.is_compressed, got.is_compressed);
            bad++;
        end
        if (got.illegal !== exp.illegal) begin
            $display("MISMATCH out.illegal exp %h got %h", exp.illegal, got.illegal);
            bad++;
        end
        if (got.bus_err !== exp.bus_err) begin
            $display("MISMATCH out.bus_err exp %h got %h", exp.bus_err, got.bus_err);
            bad++;
        end
        errors += bad;
        $display("test %0d pc %h instr %h %s", idx, got.pc, got.instr, bad ? "bad" : "ok");
    endtask

    // every read must be the expected word and an instruction access
    task automatic check_ar(input fetch_pkg::axil_ar_t got, input fetch_pkg::axil_ar_t exp);
        ar_checks++;
        if (got.addr !== exp.addr) begin
            $display("MISMATCH ar.addr exp %h got %h", exp.addr, got.addr);
            errors++;
        end
        if (got.prot !== exp.prot) begin
            $display("MISMATCH ar.prot exp %h got %h", exp.prot, got.prot);
            errors++;
        end
    endtask

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        int w;
        w = int'(addr >> 2) % `FETCH_PROG_WORDS;  // wraps past the end
        return {prog[2*w+1], prog[2*w]};
    endfunction

    // memory model, stalls of 0-3 cycles on both channels
    always @(posedge clk) begin
        if (n_rst) begin
            if (arvalid && arready) begin
                check_ar(ar, '{addr: ar_exp, prot: 3'b100});
                ar_exp     = redir_pend ? redir_word : ar_exp + 4;  // words run in order
                redir_pend = 1'b0;
                rd_addr    = ar.addr;
                arready    <= 1'b0;
                r_pending  = 1'b1;
                r_wait     = draw_bits(2);
                ar_wait    = draw_bits(2);
            end else if (arvalid) begin
                if (ar_wait == 0)
                    arready <= 1'b1;
                else
                    ar_wait--;
            end
            // a stalled AR still carries the old stream, the redirect word follows it
            if (redirect_valid) begin
                if (arvalid && !arready) begin
                    redir_word = {redirect_pc[`FETCH_ADDR_W-1:2], 2'b00};
                    redir_pend = 1'b1;
                end else begin
                    ar_exp = {redirect_pc[`FETCH_ADDR_W-1:2], 2'b00};
                end
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end else if (r_pending) begin
                if (r_wait == 0) begin
                    rvalid    <= 1'b1;
                    r         <= '{data: read_word(rd_addr), resp: fetch_pkg::OKAY};
                    r_pending = 1'b0;
                end else begin
                    r_wait--;
                end
            end
        end
    end

    initial begin
        int  idx, ri, cycles, rnd;
        logic timed_out, hold_low;
        // halfword program, unused tail gets an address based filler
        for (int i = 0; i < NHW; i++)
            prog[i] = 16'hA001 | 16'(i << 2);
        store_wide(0, 32'h0010_0093);   // addi x1,x0,1
        store_wide(2, 32'h0020_0113);   // addi x2,x0,2
        prog[4]  = 16'h0001;            // c.nop
        prog[5]  = 16'h008D;            // c.addi x1,3
        prog[6]  = 16'h517D;            // c.li x2,-1
        store_wide(7, 32'h0030_0193);   // addi x3,x0,3 straddles
        prog[9]  = 16'h8192;            // c.mv x3,x4
        prog[10] = 16'h9192;            // c.add x3,x4
        prog[11] = 16'hA001;            // c.j, unsupported
        store_wide(12, 32'h0020_81B3);  // add x3,x1,x2
        prog[14] = 16'h0001;            // stale after redirect
        prog[15] = 16'h0001;
        prog[16] = 16'h0001;            // skipped by misaligned target
        prog[17] = 16'h517D;
        store_wide(18, 32'h0010_0093);
        prog[20] = 16'h0001;
        store_wide(21, 32'h0020_81B3);  // straddle again
        prog[23] = 16'h8192;

        n_exp = 0;
        add_exp(32'h00, 32'h0010_0093, 1'b0, 1'b0);
        add_exp(32'h04, 32'h0020_0113, 1'b0, 1'b0);
        add_exp(32'h08, 32'h0000_0013, 1'b1, 1'b0);
        add_exp(32'h0A, 32'h0030_8093, 1'b1, 1'b0);
        add_exp(32'h0C, 32'hFFF0_0113, 1'b1, 1'b0);
        add_exp(32'h0E, 32'h0030_0193, 1'b0, 1'b0);
        add_exp(32'h12, 32'h0040_01B3, 1'b1, 1'b0);
        add_exp(32'h14, 32'h0041_81B3, 1'b1, 1'b0);
        add_exp(32'h16, 32'h0000_A001, 1'b1, 1'b1);
        add_exp(32'h18, 32'h0020_81B3, 1'b0, 1'b0);
        add_exp(32'h22, 32'hFFF0_0113, 1'b1, 1'b0);
        add_exp(32'h24, 32'h0010_0093, 1'b0, 1'b0);
        add_exp(32'h28, 32'h0000_0013, 1'b1, 1'b0);
        add_exp(32'h2A, 32'h0020_81B3, 1'b0, 1'b0);
        add_exp(32'h2E, 32'h0040_01B3, 1'b1, 1'b0);
        add_exp(32'h16, 32'h0000_A001, 1'b1, 1'b1);
        add_exp(32'h18, 32'h0020_81B3, 1'b0, 1'b0);
        add_exp(32'h0E, 32'h0030_0193, 1'b0, 1'b0);
        add_exp(32'h12, 32'h0040_01B3, 1'b1, 1'b0);
        add_exp(32'h14, 32'h0041_81B3, 1'b1, 1'b0);
        redir_after[0] = 9;
        redir_pc[0]    = 32'h22;  // odd halfword target
        redir_after[1] = 14;
        redir_pc[1]    = 32'h16;
        redir_after[2] = 16;
        redir_pc[2]    = 32'h0E;  // straddle right at target

        errors     = 0;
        ar_checks  = 0;
        r_pending  = 1'b0;
        ar_wait    = 0;
        r_wait     = 0;
        ar_exp     = {RESET_PC[`FETCH_ADDR_W-1:2], 2'b00};
        redir_word = '0;
        redir_pend = 1'b0;
        n_rst          = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        arready        = 1'b0;
        rvalid         = 1'b0;
        r              = '0;
        out_ready      = 1'b0;
        repeat (3) @(posedge clk);
        n_rst <= 1'b1;

        idx       = 0;
        ri        = 0;
        cycles    = 0;
        timed_out = 1'b0;
        while (idx < NEXP && !timed_out) begin
            @(negedge clk);
            rnd = draw_bits(2);  // ready pattern drawn between rising edges
            @(posedge clk);
            cycles++;
            hold_low = 1'b0;
            redirect_valid <= 1'b0;
            if (out_valid && out_ready) begin
                check_out(out, exp_tab[idx], idx);
                if (ri < NRED && redir_after[ri] == idx) begin
                    redirect_valid <= 1'b1;
                    redirect_pc    <= redir_pc[ri];
                    hold_low       = 1'b1;  // nothing may leave in the flush cycle
                    ri++;
                end
                idx++;
            end
            out_ready <= hold_low ? 1'b0 : (rnd != 0);
            if (cycles >= LIMIT)
                timed_out = 1'b1;
        end

        if (timed_out)
            $display("timeout after %0d cycles with %0d of %0d outputs seen",
                     cycles, idx, NEXP);
        $display("outputs %0d/%0d, ar checks %0d, errors %0d", idx, NEXP, ar_checks, errors);
        if (errors == 0 && !timed_out)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule
